//--- cpu_pkg.sv
package cpu_pkg;

    // Major opcodes
    localparam logic [5:0] op_r_type = 6'h00;
    localparam logic [5:0] op_addi   = 6'h08;
    localparam logic [5:0] op_andi   = 6'h0c;
    localparam logic [5:0] op_ori    = 6'h0d;
    localparam logic [5:0] op_lui    = 6'h0f;

    // Function codes, R-type only
    localparam logic [5:0] fn_add = 6'h20;
    localparam logic [5:0] fn_sub = 6'h22;
    localparam logic [5:0] fn_and = 6'h24;
    localparam logic [5:0] fn_or  = 6'h25;
    localparam logic [5:0] fn_xor = 6'h26;
    localparam logic [5:0] fn_slt = 6'h2a;

    // ALU operation, pass_none marks an encoding that writes nothing
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_lui,
        alu_pass_none
    } alu_op_e;

    // Register-format instruction fields, msb first
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_r_t;

    // Immediate-format instruction fields
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } instr_i_t;

    // Fetch to decode
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
    } if_id_t;

    // Decode to execute, operands already resolved
    typedef struct packed {
        logic        valid;
        logic        wen;
        logic [4:0]  dest;
        alu_op_e     alu_op;
        logic [31:0] a;
        logic [31:0] b;
    } id_ex_t;

    // Writeback bundle
    typedef struct packed {
        logic        valid;
        logic        wen;
        logic [4:0]  dest;
        logic [31:0] data;
    } wb_t;

endpackage

//--- instr_mem.sv
`timescale 1ns/1ps

module instr_mem #(
    parameter int mem_bytes = 512,
    localparam int addr_w = $clog2(mem_bytes)
) (
    input  logic              clk,
    // Program load port, one byte per cycle
    input  logic              prog_we,
    input  logic [addr_w-1:0] prog_addr,
    input  logic [7:0]        prog_byte,
    // Fetch read port
    input  logic [addr_w-1:0] addr,
    output logic [31:0]       instr
);

    // Byte storage, no reset on contents
    logic [7:0] mem [mem_bytes];

    // Addresses of the three following bytes
    logic [addr_w-1:0] addr_1;
    logic [addr_w-1:0] addr_2;
    logic [addr_w-1:0] addr_3;

    // Byte write from the load port
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_byte;
        end
    end

    // Wraps at the end of memory through the address width
    assign addr_1 = addr + addr_w'(1);
    assign addr_2 = addr + addr_w'(2);
    assign addr_3 = addr + addr_w'(3);

    // Big-endian, lowest address lands in the top byte
    assign instr = {mem[addr], mem[addr_1], mem[addr_2], mem[addr_3]};

    // Fetch only ever presents word-aligned pcs
    a_addr_aligned: assert property (@(posedge clk) addr[1:0] == 2'b00)
        else $error("instr_mem: unaligned fetch address %0h", addr);

endmodule

//--- fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter int mem_bytes = 512,
    localparam int addr_w = $clog2(mem_bytes)
) (
    input  logic              clk,
    input  logic              reset,
    // Level, one instruction per cycle while high
    input  logic              run,
    // Instruction memory side
    output logic [addr_w-1:0] pc,
    input  logic [31:0]       instr,
    // To decode
    output cpu_pkg::if_id_t   if_id
);

    // Next sequential pc
    logic [addr_w-1:0] pc_next;

    // Step by one word, wraps modulo mem_bytes
    assign pc_next = pc + addr_w'(4);

    // Program counter
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (run) begin
            pc <= pc_next;
        end
    end

    // Fetch to decode register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            if_id <= '0;
        end else begin
            // Slot is live only in run cycles
            if_id.valid <= run;
            // Zero-extend the short memory address
            if_id.pc    <= 32'(pc);
            if_id.instr <= instr;
        end
    end

    // A live slot only follows a run cycle outside reset
    a_valid_from_run: assert property (
        @(posedge clk) $rose(if_id.valid) |-> !reset && $past(run)
    ) else $error("fetch_stage: if_id valid rose without run");

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic         clk,
    input  logic         reset,
    // Read ports, combinational
    input  logic [4:0]   rd_a_idx,
    input  logic [4:0]   rd_b_idx,
    output logic [31:0]  rd_a,
    output logic [31:0]  rd_b,
    // Write port fed by the writeback bundle
    input  cpu_pkg::wb_t wb
);

    // Architectural registers
    logic [31:0] regs [32];

    // Write qualifier that keeps register zero unwritten
    logic do_write;

    assign do_write = wb.valid && wb.wen && (wb.dest != 5'd0);

    // Clear all on reset and write at most one register per cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (do_write) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // Register zero reads as zero
    assign rd_a = (rd_a_idx == 5'd0) ? 32'd0 : regs[rd_a_idx];
    assign rd_b = (rd_b_idx == 5'd0) ? 32'd0 : regs[rd_b_idx];

endmodule

//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk,
    input  logic              reset,
    // From fetch
    input  cpu_pkg::if_id_t   if_id,
    // Register file read ports
    output logic [4:0]        rs_idx,
    output logic [4:0]        rt_idx,
    input  logic [31:0]       rs_val,
    input  logic [31:0]       rt_val,
    // Writeback for the bypass
    input  cpu_pkg::wb_t      wb,
    // To execute
    output cpu_pkg::id_ex_t   id_ex
);

    import cpu_pkg::*;

    // Two views of the same instruction word
    instr_r_t    fr;
    instr_i_t    fi;

    // Control decode
    alu_op_e     alu_op;
    logic [4:0]  dest;
    logic        wen_op;
    logic        wen_dec;

    // Result of the slot now in execute
    logic [31:0] ex_res;
    logic        ex_rs;
    logic        ex_rt;

    // Bypassed source values
    logic        byp_rs;
    logic        byp_rt;
    logic [31:0] rs_fwd;
    logic [31:0] rt_fwd;

    // Second operand
    logic [31:0] b_sel;

    assign fr = if_id.instr;
    assign fi = if_id.instr;

    assign rs_idx = fr.rs;
    assign rt_idx = fr.rt;

    // Opcode and funct to ALU op and destination
    always_comb begin
        alu_op = alu_pass_none;
        wen_op = 1'b0;
        dest   = fi.rt;
        b_sel  = rt_fwd;
        case (fr.opcode)
            op_r_type: begin
                dest   = fr.rd;
                wen_op = 1'b1;
                case (fr.funct)
                    fn_add:  alu_op = alu_add;
                    fn_sub:  alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_slt:  alu_op = alu_slt;
                    default: begin
                        alu_op = alu_pass_none;
                        wen_op = 1'b0;
                    end
                endcase
            end
            op_addi: begin
                alu_op = alu_add;
                wen_op = 1'b1;
                // Sign-extended immediate
                b_sel  = {{16{fi.imm[15]}}, fi.imm};
            end
            op_andi: begin
                alu_op = alu_and;
                wen_op = 1'b1;
                b_sel  = {16'h0000, fi.imm};
            end
            op_ori: begin
                alu_op = alu_or;
                wen_op = 1'b1;
                b_sel  = {16'h0000, fi.imm};
            end
            op_lui: begin
                alu_op = alu_lui;
                wen_op = 1'b1;
                b_sel  = {fi.imm, 16'h0000};
            end
            default: alu_op = alu_pass_none;
        endcase
    end

    // Known op with a real destination so that r0 writes give no result
    assign wen_dec = wen_op && (dest != 5'd0);

    // Value the previous instruction is producing in execute this cycle
    always_comb begin
        case (id_ex.alu_op)
            alu_add: ex_res = id_ex.a + id_ex.b;
            alu_sub: ex_res = id_ex.a - id_ex.b;
            alu_and: ex_res = id_ex.a & id_ex.b;
            alu_or:  ex_res = id_ex.a | id_ex.b;
            alu_xor: ex_res = id_ex.a ^ id_ex.b;
            alu_slt: ex_res = {31'd0, $signed(id_ex.a) < $signed(id_ex.b)};
            alu_lui: ex_res = id_ex.b;
            default: ex_res = 32'd0;
        endcase
    end

    // Back-to-back dependency, id_ex.wen already implies valid and a non-zero dest
    assign ex_rs = id_ex.wen && (id_ex.dest == fr.rs);
    assign ex_rt = id_ex.wen && (id_ex.dest == fr.rt);

    // Take writeback data when it targets a source this cycle
    assign byp_rs = wb.valid && wb.wen && (wb.dest != 5'd0) && (wb.dest == fr.rs);
    assign byp_rt = wb.valid && wb.wen && (wb.dest != 5'd0) && (wb.dest == fr.rt);

    // Newest producer wins
    assign rs_fwd = ex_rs ? ex_res : (byp_rs ? wb.data : rs_val);
    assign rt_fwd = ex_rt ? ex_res : (byp_rt ? wb.data : rt_val);

    // Decode to execute register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_ex <= '0;
        end else begin
            id_ex.valid  <= if_id.valid;
            id_ex.wen    <= if_id.valid && wen_dec;
            id_ex.dest   <= dest;
            id_ex.alu_op <= alu_op;
            id_ex.a      <= rs_fwd;
            id_ex.b      <= b_sel;
        end
    end

    // A write always carries a real operation into execute
    a_wen_has_op: assert property (
        @(posedge clk) disable iff (reset) id_ex.wen |-> id_ex.alu_op != alu_pass_none
    ) else $error("decode_stage: wen set with pass_none");

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic            clk,
    input  logic            reset,
    // From decode
    input  cpu_pkg::id_ex_t id_ex,
    // Writeback bundle to register file, bypass and result ports
    output cpu_pkg::wb_t    wb
);

    import cpu_pkg::*;

    // ALU result for the current slot
    logic [31:0] alu_res;

    // Signed compare for slt
    logic        lt_signed;

    assign lt_signed = $signed(id_ex.a) < $signed(id_ex.b);

    // ALU
    always_comb begin
        case (id_ex.alu_op)
            alu_add: begin
                alu_res = id_ex.a + id_ex.b;
            end
            alu_sub: begin
                alu_res = id_ex.a - id_ex.b;
            end
            alu_and: begin
                alu_res = id_ex.a & id_ex.b;
            end
            alu_or: begin
                alu_res = id_ex.a | id_ex.b;
            end
            alu_xor: begin
                alu_res = id_ex.a ^ id_ex.b;
            end
            alu_slt: begin
                // One or zero
                alu_res = {31'd0, lt_signed};
            end
            alu_lui: begin
                // Decode already shifted the immediate up
                alu_res = id_ex.b;
            end
            default: begin
                alu_res = 32'd0;
            end
        endcase
    end

    // Writeback register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb <= '0;
        end else begin
            wb.valid <= id_ex.valid;
            wb.wen   <= id_ex.valid && id_ex.wen;
            wb.dest  <= id_ex.dest;
            wb.data  <= alu_res;
        end
    end

endmodule

//--- simple_pipeline.sv
`timescale 1ns/1ps

module simple_pipeline #(
    parameter int mem_bytes = 512,
    localparam int addr_w = $clog2(mem_bytes)
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              run,
    // Program load, only while run is low
    input  logic              prog_we,
    input  logic [addr_w-1:0] prog_addr,
    input  logic [7:0]        prog_byte,
    // One register write per cycle at most
    output logic              result_valid,
    output logic [4:0]        result_reg,
    output logic [31:0]       result_data
);

    import cpu_pkg::*;

    // Fetch side
    logic [addr_w-1:0] pc;
    logic [31:0]       instr;

    // Stage bundles
    if_id_t            if_id;
    id_ex_t            id_ex;
    wb_t               wb;

    // Register file reads
    logic [4:0]        rs_idx;
    logic [4:0]        rt_idx;
    logic [31:0]       rs_val;
    logic [31:0]       rt_val;

    instr_mem #(.mem_bytes(mem_bytes)) i_instr_mem (
        .clk       (clk),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_byte (prog_byte),
        .addr      (pc),
        .instr     (instr)
    );

    fetch_stage #(.mem_bytes(mem_bytes)) i_fetch (
        .clk   (clk),
        .reset (reset),
        .run   (run),
        .pc    (pc),
        .instr (instr),
        .if_id (if_id)
    );

    decode_stage i_decode (
        .clk    (clk),
        .reset  (reset),
        .if_id  (if_id),
        .rs_idx (rs_idx),
        .rt_idx (rt_idx),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .wb     (wb),
        .id_ex  (id_ex)
    );

    reg_file i_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rd_a_idx (rs_idx),
        .rd_b_idx (rt_idx),
        .rd_a     (rs_val),
        .rd_b     (rt_val),
        .wb       (wb)
    );

    execute_stage i_execute (
        .clk   (clk),
        .reset (reset),
        .id_ex (id_ex),
        .wb    (wb)
    );

    // Result ports straight off the writeback bundle
    assign result_valid = wb.valid && wb.wen;
    assign result_reg   = wb.dest;
    assign result_data  = wb.data;

endmodule

//--- tb_simple_pipeline.sv
`timescale 1ns/1ps

module tb_simple_pipeline;

    import cpu_pkg::*;

    localparam int mem_bytes = 512;
    localparam int addr_w = $clog2(mem_bytes);
    localparam int num_instr = mem_bytes / 4;
    // Run, load and some slack
    localparam int timeout_cycles = 2 * num_instr + mem_bytes + 100;

    // One expected register write
    typedef struct packed {
        logic [4:0]  dest;
        logic [31:0] data;
    } expect_t;

    logic              clk;
    logic              reset;
    logic              run;
    logic              prog_we;
    logic [addr_w-1:0] prog_addr;
    logic [7:0]        prog_byte;
    logic              result_valid;
    logic [4:0]        result_reg;
    logic [31:0]       result_data;

    integer      seed;
    int          errors;
    int          cycle_count;
    logic        run_started;
    logic [31:0] program_words [num_instr];
    logic [31:0] model_regs [32];
    expect_t     expect_q [$];
    expect_t     popped;

    simple_pipeline #(.mem_bytes(mem_bytes)) i_dut (
        .clk          (clk),
        .reset        (reset),
        .run          (run),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_byte    (prog_byte),
        .result_valid (result_valid),
        .result_reg   (result_reg),
        .result_data  (result_data)
    );

    // 10 ns clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Compare and report one value
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            errors++;
        end
    endtask

    // Mostly r0..r7 so that instructions depend on each other
    task automatic pick_reg(output logic [4:0] r);
        if (($random(seed) & 7) == 0) begin
            r = $random(seed);
        end else begin
            r = $random(seed) & 7;
        end
    endtask

    // One random instruction word
    task automatic gen_instr(output logic [31:0] w);
        int          kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        kind = $unsigned($random(seed)) % 16;
        pick_reg(rs);
        pick_reg(rt);
        pick_reg(rd);
        imm = $random(seed);
        case (kind)
            0, 1:    w = {op_r_type, rs, rt, rd, 5'd0, fn_add};
            2, 14:   w = {op_r_type, rs, rt, rd, 5'd0, fn_sub};
            3:       w = {op_r_type, rs, rt, rd, 5'd0, fn_and};
            4:       w = {op_r_type, rs, rt, rd, 5'd0, fn_or};
            5:       w = {op_r_type, rs, rt, rd, 5'd0, fn_xor};
            6, 7:    w = {op_r_type, rs, rt, rd, 5'd0, fn_slt};
            8, 9:    w = {op_addi, rs, rt, imm};
            10:      w = {op_andi, rs, rt, imm};
            11:      w = {op_ori, rs, rt, imm};
            12, 13:  w = {op_lui, 5'd0, rt, imm};
            // Unknown: a load opcode, or R-type sll
            default: w = imm[0] ? {6'h23, rs, rt, imm} : {op_r_type, rs, rt, rd, 5'd0, 6'h00};
        endcase
    endtask

    // Reference model, one instruction in program order
    task automatic model_exec(input logic [31:0] w);
        logic [5:0]  opc;
        logic [5:0]  fn;
        logic [4:0]  dst;
        logic [15:0] imm;
        logic [31:0] a;
        logic [31:0] bv;
        logic [31:0] res;
        logic        writes;
        expect_t     e;
        opc    = w[31:26];
        fn     = w[5:0];
        imm    = w[15:0];
        a      = model_regs[w[25:21]];
        bv     = model_regs[w[20:16]];
        dst    = w[20:16];
        res    = 32'd0;
        writes = 1'b1;
        if (opc == op_r_type) begin
            dst = w[15:11];
            case (fn)
                fn_add:  res = a + bv;
                fn_sub:  res = a - bv;
                fn_and:  res = a & bv;
                fn_or:   res = a | bv;
                fn_xor:  res = a ^ bv;
                fn_slt:  res = ($signed(a) < $signed(bv)) ? 32'd1 : 32'd0;
                default: writes = 1'b0;
            endcase
        end else if (opc == op_addi) begin
            res = a + {{16{imm[15]}}, imm};
        end else if (opc == op_andi) begin
            res = a & {16'h0000, imm};
        end else if (opc == op_ori) begin
            res = a | {16'h0000, imm};
        end else if (opc == op_lui) begin
            res = {imm, 16'h0000};
        end else begin
            writes = 1'b0;
        end
        // r0 stays zero and gives no result
        if (writes && dst != 5'd0) begin
            model_regs[dst] = res;
            e.dest = dst;
            e.data = res;
            expect_q.push_back(e);
        end
    endtask

    // Scoreboard, sampled away from the rising edge
    always @(negedge clk) begin
        if (!reset && result_valid) begin
            if (!run_started) begin
                $display("Error at %0t ns: result_valid high before run was raised", $time);
                errors++;
            end else if (expect_q.size() == 0) begin
                $display("Error at %0t ns: extra result for register %0d", $time, result_reg);
                errors++;
            end else begin
                popped = expect_q.pop_front();
                check_value("result_reg", 32'(result_reg), 32'(popped.dest));
                check_value("result_data", result_data, popped.data);
            end
        end
    end

    // Timeout
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Error: run did not finish within %0d cycles", timeout_cycles);
            $display("Errors: %0d", errors + 1);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        reset       = 1'b1;
        run         = 1'b0;
        prog_we     = 1'b0;
        prog_addr   = '0;
        prog_byte   = 8'h00;
        seed        = 32'hd62;
        errors      = 0;
        cycle_count = 0;
        run_started = 1'b0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = 32'd0;
        end
        // Program and expected results up front
        for (int i = 0; i < num_instr; i++) begin
            gen_instr(program_words[i]);
            model_exec(program_words[i]);
        end
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        // Load byte by byte, most significant byte at the lowest address
        for (int i = 0; i < mem_bytes; i++) begin
            prog_we   = 1'b1;
            prog_addr = i;
            prog_byte = program_words[i / 4][31 - 8 * (i % 4) -: 8];
            @(posedge clk);
            #1;
        end
        prog_we = 1'b0;
        // Exactly one pass over memory
        run         = 1'b1;
        run_started = 1'b1;
        repeat (num_instr) begin
            @(posedge clk);
            #1;
        end
        run = 1'b0;
        // Drain the pipeline
        repeat (10) @(posedge clk);
        if (expect_q.size() != 0) begin
            $display("Error: %0d expected results never appeared", expect_q.size());
            errors++;
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- simple_pipeline.f
cpu_pkg.sv
instr_mem.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
simple_pipeline.sv
tb_simple_pipeline.sv
